// File: condTest.sv
`timescale 1ns/1ps
`default_nettype none

module condTest (
  input wire logic [0:35] adData,
  input wire logic adCarry,
  input wire logic [7:8] magic,
  input wire logic [0:2] dramB,
  output logic adEq0,
  output logic testSatisfied,
  output logic [0:2] norm
);

  logic aGtB;
  logic magicEq;
  logic termEq;
  logic termGt;
  logic termLt;
  logic termX;

  assign adEq0 = ~|adData;

  // Sign corrected by the carry out
  assign aGtB = adData[0] ^ adCarry;
  assign magicEq = magic[7] == magic[8];

  assign termEq = dramB[1] & adEq0;
  assign termGt = dramB[2] & aGtB & magic[7];
  assign termLt = dramB[2] & adData[0] & magic[8];
  assign termX = magicEq & adCarry;

  // B[0] inverts the sense of the skip
  assign testSatisfied = (termEq | termGt | termLt | termX) ^ dramB[0];

  // Normalize priority code, highest bit wins
  always_comb begin
    if (adData[0]) begin
      norm = 3'd1;
    end else if (|adData[1:6]) begin
      norm = 3'd2;
    end else if (adData[7]) begin
      norm = 3'd3;
    end else if (adData[8]) begin
      norm = 3'd4;
    end else if (adData[9]) begin
      norm = 3'd5;
    end else if (adData[10]) begin
      norm = 3'd6;
    end else if (|adData[11:35]) begin
      norm = 3'd7;
    end else begin
      norm = 3'd0;
    end
  end

endmodule

`default_nettype wire

// File: diagReadMux.sv
`timescale 1ns/1ps
`default_nettype none
`include "kl10_config.svh"

module diagReadMux (
  input wire logic diagRead,
  input wire logic [4:6] diagFunc,
  input wire logic [0:2] norm,
  input wire logic [0:`DRADR_WIDTH-1] dradr,
  input wire logic enIoJrst,
  input wire logic enAc,
  input wire logic [0:3] irAc,
  input wire logic [0:2] dramA,
  input wire logic [0:2] dramB,
  input wire logic testSatisfied,
  input wire logic jrst0,
  input wire logic [1:4] dramJHigh,
  input wire logic dramPar,
  input wire logic dramParityOk,
  input wire logic [7:10] dramJLow,
  input wire logic adEq0,
  input wire logic ioLegal,
  input wire logic acEq0,
  input wire logic adCarry,
  input wire logic [7:8] magic,
  input wire logic [7:12] irLow,
  output logic ebusDriving,
  output logic [0:5] ebusData
);

  dramPkg::diagGroup_t group;

  assign group = dramPkg::diagGroup_t'(diagFunc);
  assign ebusDriving = diagRead;

  // Bus floats low when nobody reads
  always_comb begin
    ebusData = '0;
    if (diagRead) begin
      case (group)
        dramPkg::grpNormDradr: ebusData = {norm, dradr[0:2]};
        dramPkg::grpDradrLow: ebusData = dradr[3:8];
        dramPkg::grpEnables: ebusData = {enIoJrst, enAc, irAc};
        dramPkg::grpDramAB: ebusData = {dramA, dramB};
        dramPkg::grpTestJHigh: ebusData = {testSatisfied, jrst0, dramJHigh};
        dramPkg::grpParJLow: ebusData = {dramPar, dramParityOk, dramJLow};
        dramPkg::grpAdStatus: ebusData = {adEq0, ioLegal, acEq0, adCarry, magic};
        dramPkg::grpIrLow: ebusData = irLow;
        default: ebusData = '0;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: dramDispatch.sv
`timescale 1ns/1ps
`default_nettype none
`include "kl10_config.svh"

module dramDispatch (
  input wire logic eboxClk,
  input wire logic arstN,
  input wire logic loadDRAM,
  input wire logic diagLoad,
  input wire logic [0:6] diagFunc,
  input dramPkg::dramWord_t ebusWord,
  input irFormatPkg::irWord_t ir,
  input wire logic enIoJrst,
  input wire logic jrst,
  output logic [0:`DRADR_WIDTH-1] dradr,
  output logic [0:2] dramA,
  output logic [0:2] dramB,
  output logic [0:10] dramJ,
  output logic dramPar,
  output logic dramParityOk
);

  dramPkg::dramWord_t dramMem [0:`DRAM_DEPTH-1];

  logic ioDispatch;
  logic devAllOnes;
  logic [0:2] ioMid;
  logic [0:`DRADR_WIDTH-1] ioAdr;
  logic [0:`DRADR_WIDTH-1] nextAdr;
  logic readStage;
  logic dramWrite;
  dramPkg::dramWord_t wordQ;
  logic [7:10] jLowQ;

  // 7xx instructions dispatch through the I/O page when enabled
  assign ioDispatch = (ir.io.prefix == irFormatPkg::ioPrefix) & enIoJrst;

  // Devices 74x-77x share one slot
  assign devAllOnes = &ir.io.device[0:3];
  assign ioMid = devAllOnes ? 3'o7 : ir.io.device[3:5];
  assign ioAdr = {3'o7, ioMid, ir.io.func};

  assign nextAdr = ioDispatch ? ioAdr : ir.basic.opcode;

  always_ff @(posedge eboxClk or negedge arstN) begin
    if (!arstN) begin
      dradr <= '0;
    end else if (loadDRAM) begin
      dradr <= nextAdr;
    end
  end

  // Second stage of the lookup, one edge behind loadDRAM
  always_ff @(posedge eboxClk or negedge arstN) begin
    if (!arstN) begin
      readStage <= 1'b0;
    end else begin
      readStage <= loadDRAM;
    end
  end

  assign dramWrite = diagLoad && (diagFunc == `DIAG_LOAD_DRAM);

  // Only the diagnostic port writes the array
  always_ff @(posedge eboxClk) begin
    if (dramWrite) begin
      dramMem[dradr] <= ebusWord;
    end
  end

  // Registered word, with JRST taking J7-10 from the AC field
  always_ff @(posedge eboxClk or negedge arstN) begin
    if (!arstN) begin
      wordQ <= '0;
      jLowQ <= '0;
    end else if (readStage) begin
      wordQ <= dramMem[dradr];
      jLowQ <= jrst ? ir.basic.ac : dramMem[dradr].jLow;
    end
  end

  assign dramA = wordQ.a;
  assign dramB = wordQ.b;
  assign dramPar = wordQ.par;
  assign dramJ = {1'b0, wordQ.jHigh, 2'b00, jLowQ};

  // Odd parity over the word as read
  assign dramParityOk = ^wordQ;

endmodule

`default_nettype wire

// File: dramPkg.sv
`default_nettype none

package dramPkg;

  // One dispatch RAM word as written through the diagnostic port
  // Bit 0 of ebusIn lands in A[0]
  typedef struct packed {
    logic [0:2] a;
    logic [0:2] b;
    logic par;
    logic [1:4] jHigh;
    logic [7:10] jLow;
  } dramWord_t;

  // Readback groups selected by diagFunc[4:6]
  typedef enum logic [0:2] {
    // norm and DRADR[0:2]
    grpNormDradr = 3'd0,
    // DRADR[3:8]
    grpDradrLow = 3'd1,
    // enables and IRAC
    grpEnables = 3'd2,
    // A and B fields
    grpDramAB = 3'd3,
    // skip result, JRST0, J1-4
    grpTestJHigh = 3'd4,
    // parity and J7-10
    grpParJLow = 3'd5,
    // adder and decode status
    grpAdStatus = 3'd6,
    // low six IR bits
    grpIrLow = 3'd7
  } diagGroup_t;

endpackage

`default_nettype wire

// File: instrReg.sv
`timescale 1ns/1ps
`default_nettype none
`include "kl10_config.svh"

module instrReg (
  input wire logic eboxClk,
  input wire logic arstN,
  input wire logic loadIR,
  input wire logic mbXfer,
  input wire logic diagLoad,
  input wire logic [0:`IR_WIDTH-1] cacheDataRead,
  input wire logic [0:`IR_WIDTH-1] adData,
  input wire logic [0:6] diagFunc,
  input wire logic ebusBit,
  output irFormatPkg::irWord_t ir,
  output logic [0:3] irAc,
  output logic enIoJrst,
  output logic enAc,
  output logic jrst,
  output logic jrst0,
  output logic ioLegal,
  output logic acEq0
);

  logic [0:`IR_WIDTH-1] irNext;

  // Adder output during MB transfers, cache data otherwise
  assign irNext = mbXfer ? adData : cacheDataRead;

  always_ff @(posedge eboxClk or negedge arstN) begin
    if (!arstN) begin
      ir <= '0;
    end else if (loadIR) begin
      ir <= irNext;
    end
  end

  // Enable flags written by diagnostic function 065 and 066
  always_ff @(posedge eboxClk or negedge arstN) begin
    if (!arstN) begin
      enIoJrst <= 1'b0;
      enAc <= 1'b0;
    end else if (diagLoad) begin
      case (diagFunc)
        `DIAG_EN_IOJRST: begin
          enIoJrst <= ebusBit;
        end
        `DIAG_EN_AC: begin
          enAc <= ebusBit;
        end
        default: begin
        end
      endcase
    end
  end

  // Opcode decode through the basic view
  assign jrst = ir.basic.opcode == irFormatPkg::jrstOpcode;
  assign acEq0 = ir.basic.ac == 4'b0000;
  assign jrst0 = jrst & acEq0;

  // Opcode bits 3-6 are device bits 0-3 in the I/O view
  assign ioLegal = &ir.io.device[0:3];

  // AC field passed on only when enabled
  assign irAc = enAc ? ir.basic.ac : 4'b0000;

endmodule

`default_nettype wire

// File: irBoard.sv
`timescale 1ns/1ps
`default_nettype none
`include "kl10_config.svh"

module irBoard (
  input wire logic eboxClk,
  input wire logic arstN,
  input wire logic [0:35] cacheDataRead,
  input wire logic [0:35] adData,
  input wire logic adCarry,
  input wire logic mbXfer,
  input wire logic loadIR,
  input wire logic loadDRAM,
  input wire logic [7:8] magic,
  input wire logic diagLoad,
  input wire logic diagRead,
  input wire logic [0:6] diagFunc,
  input wire logic [0:35] ebusIn,
  output irFormatPkg::irWord_t ir,
  output logic [0:3] irAc,
  output logic ioLegal,
  output logic acEq0,
  output logic jrst0,
  output logic adEq0,
  output logic testSatisfied,
  output logic [0:2] norm,
  output logic [0:`DRADR_WIDTH-1] dradr,
  output logic [0:2] dramA,
  output logic [0:2] dramB,
  output logic [0:10] dramJ,
  output logic dramParityOk,
  output logic ebusDriving,
  output logic [0:5] ebusData
);

  logic enIoJrst;
  logic enAc;
  logic jrst;
  logic dramPar;

  instrReg instrReg_i (
    .eboxClk(eboxClk),
    .arstN(arstN),
    .loadIR(loadIR),
    .mbXfer(mbXfer),
    .diagLoad(diagLoad),
    .cacheDataRead(cacheDataRead[0:`IR_WIDTH-1]),
    .adData(adData[0:`IR_WIDTH-1]),
    .diagFunc(diagFunc),
    .ebusBit(ebusIn[0]),
    .ir(ir),
    .irAc(irAc),
    .enIoJrst(enIoJrst),
    .enAc(enAc),
    .jrst(jrst),
    .jrst0(jrst0),
    .ioLegal(ioLegal),
    .acEq0(acEq0)
  );

  // DRAM word arrives on EBUS bits 0-14
  dramDispatch dramDispatch_i (
    .eboxClk(eboxClk),
    .arstN(arstN),
    .loadDRAM(loadDRAM),
    .diagLoad(diagLoad),
    .diagFunc(diagFunc),
    .ebusWord(ebusIn[0:14]),
    .ir(ir),
    .enIoJrst(enIoJrst),
    .jrst(jrst),
    .dradr(dradr),
    .dramA(dramA),
    .dramB(dramB),
    .dramJ(dramJ),
    .dramPar(dramPar),
    .dramParityOk(dramParityOk)
  );

  condTest condTest_i (
    .adData(adData),
    .adCarry(adCarry),
    .magic(magic),
    .dramB(dramB),
    .adEq0(adEq0),
    .testSatisfied(testSatisfied),
    .norm(norm)
  );

  // IR bits 7-12 are the low six bits of the packed word
  diagReadMux diagReadMux_i (
    .diagRead(diagRead),
    .diagFunc(diagFunc[4:6]),
    .norm(norm),
    .dradr(dradr),
    .enIoJrst(enIoJrst),
    .enAc(enAc),
    .irAc(irAc),
    .dramA(dramA),
    .dramB(dramB),
    .testSatisfied(testSatisfied),
    .jrst0(jrst0),
    .dramJHigh(dramJ[1:4]),
    .dramPar(dramPar),
    .dramParityOk(dramParityOk),
    .dramJLow(dramJ[7:10]),
    .adEq0(adEq0),
    .ioLegal(ioLegal),
    .acEq0(acEq0),
    .adCarry(adCarry),
    .magic(magic),
    .irLow(ir[5:0]),
    .ebusDriving(ebusDriving),
    .ebusData(ebusData)
  );

endmodule

`default_nettype wire

// File: irBoard_asserts.sv
`timescale 1ns/1ps
`default_nettype none
`include "kl10_config.svh"

module irBoard_asserts (
  input wire logic eboxClk,
  input wire logic arstN,
  input wire logic loadDRAM,
  input wire logic diagRead,
  input wire logic [0:`DRADR_WIDTH-1] dradr,
  input wire logic ebusDriving,
  input wire logic [0:5] ebusData
);

  // Number of failed assertions so far
  int failCount = 0;

  // EBUS is driven exactly while a readback is requested
  property drivingFollowsRead;
    @(posedge eboxClk) disable iff (!arstN)
      ebusDriving == diagRead;
  endproperty

  // Idle bus carries zero
  property idleBusZero;
    @(posedge eboxClk) disable iff (!arstN)
      !ebusDriving |-> ebusData == 6'd0;
  endproperty

  // Dispatch address only moves on a loadDRAM edge
  property dradrHolds;
    @(posedge eboxClk) disable iff (!arstN)
      !loadDRAM |=> $stable(dradr);
  endproperty

  drivingCheck: assert property (drivingFollowsRead)
    else begin
      $error("ebusDriving differs from diagRead");
      failCount++;
    end

  idleCheck: assert property (idleBusZero)
    else begin
      $error("ebusData nonzero while EBUS not driven");
      failCount++;
    end

  holdCheck: assert property (dradrHolds)
    else begin
      $error("dradr changed without loadDRAM");
      failCount++;
    end

endmodule

`default_nettype wire

// File: irBoard_tb.sv
`timescale 1ns/1ps
`default_nettype none
`include "kl10_config.svh"

module irBoard_tb;

  localparam int clkPeriod = 40;
  localparam int cyclesPerRow = 24;

  typedef struct {
    irFormatPkg::irWord_t ir;
    logic mbx;
    logic enIo;
    logic enAcSet;
    dramPkg::dramWord_t word;
    logic [7:8] mag;
    logic carry;
    logic [0:35] ad;
    logic rnd;
    logic [0:2] expNorm;
  } rowT;

  logic eboxClk;
  logic arstN;
  logic [0:35] cacheDataRead;
  logic [0:35] adData;
  logic adCarry;
  logic mbXfer;
  logic loadIR;
  logic loadDRAM;
  logic [7:8] magic;
  logic diagLoad;
  logic diagRead;
  logic [0:6] diagFunc;
  logic [0:35] ebusIn;
  irFormatPkg::irWord_t ir;
  logic [0:3] irAc;
  logic ioLegal;
  logic acEq0;
  logic jrst0;
  logic adEq0;
  logic testSatisfied;
  logic [0:2] norm;
  logic [0:`DRADR_WIDTH-1] dradr;
  logic [0:2] dramA;
  logic [0:2] dramB;
  logic [0:10] dramJ;
  logic dramParityOk;
  logic ebusDriving;
  logic [0:5] ebusData;

  rowT rows[$];
  logic [31:0] lfsr;
  int valueErrors;
  int otherErrors;

  irBoard irBoard_i (.*);

  bind irBoard irBoard_asserts irBoard_asserts_i (
    .eboxClk(eboxClk),
    .arstN(arstN),
    .loadDRAM(loadDRAM),
    .diagRead(diagRead),
    .dradr(dradr),
    .ebusDriving(ebusDriving),
    .ebusData(ebusData)
  );

  initial begin
    eboxClk = 1'b0;
    forever #(clkPeriod / 2) eboxClk = ~eboxClk;
  end

  // Taps 32, 22, 2, 1
  function automatic logic lfsrBit();
    logic fb;
    fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
    lfsr = {lfsr[30:0], fb};
    return fb;
  endfunction

  function automatic logic [35:0] randBits(int n);
    logic [35:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[34:0], lfsrBit()};
    end
    return v;
  endfunction

  function automatic logic [0:8] modelDradr(irFormatPkg::irWord_t w, logic enIo);
    logic [0:2] mid;
    if (w.io.prefix == 3'o7 && enIo) begin
      mid = (w.io.device[0:3] == 4'b1111) ? 3'o7 : w.io.device[3:5];
      return {3'o7, mid, w.io.func};
    end
    return w.basic.opcode;
  endfunction

  function automatic logic modelTest(logic [0:35] ad, logic carry, logic [7:8] mag,
                                     logic [0:2] b);
    logic zero;
    logic anyTerm;
    zero = (ad == 36'd0);
    anyTerm = (b[1] && zero) || (b[2] && (ad[0] != carry) && mag[7]) ||
              (b[2] && ad[0] && mag[8]) || ((mag[7] == mag[8]) && carry);
    return b[0] ? !anyTerm : anyTerm;
  endfunction

  // First set bit from the left picks the level
  function automatic logic [0:2] modelNorm(logic [0:35] ad);
    for (int i = 0; i < 36; i++) begin
      if (ad[i]) begin
        if (i == 0) return 3'd1;
        if (i <= 6) return 3'd2;
        if (i <= 10) return 3'(i - 4);
        return 3'd7;
      end
    end
    return 3'd0;
  endfunction

  task automatic valueError(string name, logic [63:0] expV, logic [63:0] actV);
    $display("ERR t=%0t %s expected %0h actual %0h", $time, name, expV, actV);
    valueErrors++;
  endtask

  task automatic checkIr(string name, irFormatPkg::irWord_t expV, irFormatPkg::irWord_t actV);
    if (expV !== actV) valueError(name, 64'(expV), 64'(actV));
  endtask

  task automatic checkDram(string name, dramPkg::dramWord_t expV, dramPkg::dramWord_t actV);
    if (expV !== actV) valueError(name, 64'(expV), 64'(actV));
  endtask

  task automatic checkBit(string name, logic expV, logic actV);
    if (expV !== actV) valueError(name, 64'(expV), 64'(actV));
  endtask

  task automatic checkNorm(string name, logic [0:2] expV, logic [0:2] actV);
    if (expV !== actV) valueError(name, 64'(expV), 64'(actV));
  endtask

  task automatic checkAdr(string name, logic [0:8] expV, logic [0:8] actV);
    if (expV !== actV) valueError(name, 64'(expV), 64'(actV));
  endtask

  task automatic checkAc(string name, logic [0:3] expV, logic [0:3] actV);
    if (expV !== actV) valueError(name, 64'(expV), 64'(actV));
  endtask

  task automatic checkEbus(string name, logic [0:5] expV, logic [0:5] actV, logic drvExp);
    if (ebusDriving !== drvExp) begin
      $display("ebusDriving does not follow diagRead at t=%0t", $time);
      otherErrors++;
    end
    if (expV !== actV) valueError(name, 64'(expV), 64'(actV));
  endtask

  task automatic addRow(logic [12:0] irBits, logic mbx, logic enIo, logic enAcSet,
                        logic [14:0] word, logic [7:8] mag, logic carry,
                        logic [0:35] ad, logic rnd, logic [0:2] expNorm);
    rowT r;
    r.ir = irBits;
    r.mbx = mbx;
    r.enIo = enIo;
    r.enAcSet = enAcSet;
    r.word = word;
    r.mag = mag;
    r.carry = carry;
    r.ad = ad;
    r.rnd = rnd;
    r.expNorm = expNorm;
    rows.push_back(r);
  endtask

  task automatic applyAd(rowT r, logic [0:35] ad, logic [7:8] mag, logic carry);
    @(posedge eboxClk);
    adData <= ad;
    magic <= mag;
    adCarry <= carry;
    @(negedge eboxClk);
    checkBit("adEq0", ad == 36'd0, adEq0);
    checkNorm("norm", modelNorm(ad), norm);
    if (!r.rnd) checkNorm("norm table", r.expNorm, norm);
    checkBit("testSatisfied", modelTest(ad, carry, mag, r.word.b), testSatisfied);
  endtask

  task automatic runRow(rowT r);
    logic [0:8] expAdr;
    logic isJrst;
    logic [0:3] expIrAc;
    logic [0:35] ad;
    logic [7:8] mag;
    logic carry;
    dramPkg::dramWord_t expWord;
    dramPkg::dramWord_t actWord;
    logic [0:5] expGrp[8];
    expAdr = modelDradr(r.ir, r.enIo);
    isJrst = r.ir.basic.opcode == 9'o254;
    expIrAc = r.enAcSet ? r.ir.basic.ac : 4'b0000;
    // IR load together with the I/O-JRST enable
    @(posedge eboxClk);
    loadIR <= 1'b1;
    mbXfer <= r.mbx;
    cacheDataRead <= r.mbx ? 36'd0 : {r.ir, 23'd0};
    adData <= r.mbx ? {r.ir, 23'd0} : 36'd0;
    diagLoad <= 1'b1;
    diagFunc <= `DIAG_EN_IOJRST;
    ebusIn <= {r.enIo, 35'd0};
    @(posedge eboxClk);
    loadIR <= 1'b0;
    diagFunc <= `DIAG_EN_AC;
    ebusIn <= {r.enAcSet, 35'd0};
    @(posedge eboxClk);
    diagLoad <= 1'b0;
    loadDRAM <= 1'b1;
    // Write the word at the address just formed
    @(posedge eboxClk);
    loadDRAM <= 1'b0;
    diagLoad <= 1'b1;
    diagFunc <= `DIAG_LOAD_DRAM;
    ebusIn <= {r.word, 21'd0};
    @(negedge eboxClk);
    checkIr("ir", r.ir, ir);
    checkAc("irAc", expIrAc, irAc);
    checkAdr("dradr", expAdr, dradr);
    checkBit("jrst0", isJrst && r.ir.basic.ac == 4'd0, jrst0);
    checkBit("ioLegal", &r.ir.basic.opcode[3:6], ioLegal);
    checkBit("acEq0", r.ir.basic.ac == 4'd0, acEq0);
    @(posedge eboxClk);
    diagLoad <= 1'b0;
    loadDRAM <= 1'b1;
    @(posedge eboxClk);
    loadDRAM <= 1'b0;
    // Fields are valid two edges after loadDRAM
    @(posedge eboxClk);
    @(negedge eboxClk);
    expWord = r.word;
    if (isJrst) expWord.jLow = r.ir.basic.ac;
    actWord = {dramA, dramB, irBoard_i.dramDispatch_i.dramPar, dramJ[1:4], dramJ[7:10]};
    checkDram("dram fields", expWord, actWord);
    checkBit("dramJ spare bits", 1'b0, dramJ[0] | dramJ[5] | dramJ[6]);
    checkBit("dramParityOk", ^r.word, dramParityOk);
    ad = r.ad;
    mag = r.mag;
    carry = r.carry;
    if (r.rnd) begin
      for (int k = 0; k < 3; k++) begin
        ad = randBits(36) >> randBits(5);
        mag = 2'(randBits(2));
        carry = lfsrBit();
        applyAd(r, ad, mag, carry);
      end
    end else begin
      applyAd(r, ad, mag, carry);
    end
    expGrp[0] = {modelNorm(ad), expAdr[0:2]};
    expGrp[1] = expAdr[3:8];
    expGrp[2] = {r.enIo, r.enAcSet, expIrAc};
    expGrp[3] = {r.word.a, r.word.b};
    expGrp[4] = {modelTest(ad, carry, mag, r.word.b), isJrst && r.ir.basic.ac == 4'd0,
                 r.word.jHigh};
    expGrp[5] = {r.word.par, ^r.word, expWord.jLow};
    expGrp[6] = {ad == 36'd0, &r.ir.basic.opcode[3:6], r.ir.basic.ac == 4'd0, carry, mag};
    expGrp[7] = r.ir[5:0];
    for (int g = 0; g < 8; g++) begin
      @(posedge eboxClk);
      diagRead <= 1'b1;
      diagFunc <= `DIAG_READ_BASE | 7'(g);
      @(negedge eboxClk);
      checkEbus($sformatf("ebusData group %0d", g), expGrp[g], ebusData, 1'b1);
    end
    @(posedge eboxClk);
    diagRead <= 1'b0;
    @(negedge eboxClk);
    checkEbus("ebusData idle", 6'd0, ebusData, 1'b0);
  endtask

  initial begin
    arstN = 1'b0;
    cacheDataRead = '0;
    adData = '0;
    adCarry = 1'b0;
    mbXfer = 1'b0;
    loadIR = 1'b0;
    loadDRAM = 1'b0;
    magic = '0;
    diagLoad = 1'b0;
    diagRead = 1'b0;
    diagFunc = '0;
    ebusIn = '0;
    lfsr = 32'h00c2a1fb;
    valueErrors = 0;
    otherErrors = 0;
    // ir, mbx, enIo, enAc, word, magic, carry, adData, rnd, expNorm
    addRow({9'o200, 4'd3}, 0, 0, 1, {3'o1, 3'o0, 1'b1, 4'h3, 4'h9}, 2'b10, 0,
           36'h800000000, 0, 3'd1);
    addRow({9'o254, 4'd6}, 1, 0, 0, {3'o2, 3'o1, 1'b0, 4'h5, 4'hA}, 2'b01, 1,
           36'h100000000, 0, 3'd2);
    addRow({9'o254, 4'd0}, 0, 0, 1, {3'o3, 3'o2, 1'b1, 4'hF, 4'h1}, 2'b11, 1,
           36'h010000000, 0, 3'd3);
    addRow({3'o7, 7'b0010110, 3'd3}, 0, 1, 0, {3'o4, 3'o3, 1'b0, 4'h2, 4'h4}, 2'b10, 1,
           36'h008000000, 0, 3'd4);
    addRow({3'o7, 7'b1111010, 3'd5}, 1, 1, 1, {3'o5, 3'o4, 1'b1, 4'h8, 4'h7}, 2'b00, 0,
           36'h004000000, 0, 3'd5);
    addRow({3'o7, 7'b1111010, 3'd2}, 0, 0, 0, {3'o6, 3'o5, 1'b0, 4'hC, 4'h2}, 2'b01, 0,
           36'h002000000, 0, 3'd6);
    addRow({9'o123, 4'd0}, 1, 1, 0, {3'o7, 3'o6, 1'b1, 4'h1, 4'hE}, 2'b11, 0,
           36'h000008000, 0, 3'd7);
    addRow({3'o7, 7'b0101011, 3'd7}, 0, 1, 1, {3'o0, 3'o7, 1'b0, 4'h6, 4'h5}, 2'b00, 1,
           36'h000000000, 0, 3'd0);
    addRow({9'o254, 4'd9}, 0, 1, 1, {3'o2, 3'o6, 1'b1, 4'h7, 4'h3}, 2'b00, 0, '0, 1, 3'd0);
    addRow({9'o345, 4'd1}, 1, 0, 1, {3'o6, 3'o2, 1'b0, 4'h9, 4'hB}, 2'b00, 0, '0, 1, 3'd0);
    addRow({3'o7, 7'b1000100, 3'd2}, 0, 1, 0, {3'o1, 3'o4, 1'b1, 4'hD, 4'h0}, 2'b00, 0, '0, 1,
           3'd0);
    addRow({9'o071, 4'd15}, 0, 0, 1, {3'o5, 3'o7, 1'b0, 4'h4, 4'h6}, 2'b00, 0, '0, 1, 3'd0);
    repeat (3) @(posedge eboxClk);
    arstN <= 1'b1;
    foreach (rows[i]) begin
      runRow(rows[i]);
    end
    repeat (2) @(posedge eboxClk);
    $display("Checks with wrong values: %0d, other failures: %0d, assertion failures: %0d",
             valueErrors, otherErrors, irBoard_i.irBoard_asserts_i.failCount);
    if (valueErrors == 0 && otherErrors == 0 &&
        irBoard_i.irBoard_asserts_i.failCount == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  // Run length follows from the number of table rows
  initial begin
    #1;
    repeat (rows.size() * cyclesPerRow + 50) @(posedge eboxClk);
    $display("Watchdog expired before all table rows were applied");
    $display("TEST FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// File: irFormatPkg.sv
`default_nettype none

package irFormatPkg;

  // Basic instruction view
  typedef struct packed {
    logic [0:8] opcode;
    logic [0:3] ac;
  } irBasic_t;

  // I/O instruction view, prefix 7 selects the I/O space
  typedef struct packed {
    logic [0:2] prefix;
    logic [0:6] device;
    logic [0:2] func;
  } irIo_t;

  // Same 13 IR bits, decoded either way
  typedef union packed {
    irBasic_t basic;
    irIo_t io;
  } irWord_t;

  // JRST is opcode 254
  localparam logic [0:8] jrstOpcode = 9'o254;

  // Prefix of the I/O instruction space
  localparam logic [0:2] ioPrefix = 3'o7;

endpackage

`default_nettype wire

// File: kl10_config.svh
`ifndef KL10_CONFIG_SVH
`define KL10_CONFIG_SVH

// Instruction register width, opcode plus AC field
`define IR_WIDTH 13

// Dispatch RAM geometry
`define DRADR_WIDTH 9
`define DRAM_DEPTH 512

// Diagnostic load functions, 06x group
`define DIAG_LOAD_DRAM 7'o060
`define DIAG_EN_IOJRST 7'o065
`define DIAG_EN_AC 7'o066

// Diagnostic readback functions, 13x group
// Low three bits pick one of eight groups
`define DIAG_READ_BASE 7'o130

`endif

// File: run.sh
#!/usr/bin/env bash
# Build and run the irBoard testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  -f src.f --top-module irBoard_tb -o irBoard_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

output=$(./obj_dir/irBoard_sim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -qx "TEST PASSED" <<< "$output"; then
  exit 0
fi
exit 1

// File: src.f
+incdir+.
irFormatPkg.sv
dramPkg.sv
instrReg.sv
dramDispatch.sv
condTest.sv
diagReadMux.sv
irBoard.sv
irBoard_asserts.sv
irBoard_tb.sv
